// ==== source/snn_pkg.sv ====
package snn_pkg;

    typedef logic [7:0] byte_t;     // pixel, weight, beta, vth, membrane
    typedef logic [7:0] count_t;    // saturates at 255
    typedef logic [7:0] addr_t;     // loader and memory address

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        GEN,
        POP,
        INTEG,
        LEAK,
        NEXT
    } state_t;

    // loader map: image from 0, weights right after, two registers at the top
    localparam addr_t BETA_ADDR = 8'd254;
    localparam addr_t VTH_ADDR  = 8'd255;

    // spike lfsr, shift left, feedback from bits 7 5 4 3
    localparam byte_t LFSR_SEED = 8'hb5;
    localparam byte_t LFSR_TAPS = 8'b1011_1000;

endpackage

// ==== source/snn_store.sv ====
`timescale 1ns/10ps

module snn_store #(
    parameter int NUM_PIXELS  = 16,
    parameter int NUM_NEURONS = 4,
    localparam int NUM_WGT = NUM_PIXELS * NUM_NEURONS,
    localparam int PIX_W   = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    localparam int WGT_W   = (NUM_WGT > 1) ? $clog2(NUM_WGT) : 1
) (
    input  logic           clk,
    input  logic           load_we_i,
    input  snn_pkg::addr_t load_addr_i,
    input  snn_pkg::byte_t load_data_i,
    input  logic           busy_i,
    input  logic           img_rd_i,
    input  snn_pkg::addr_t img_addr_i,
    output snn_pkg::byte_t img_data_o,
    input  logic           wgt_rd_i,
    input  snn_pkg::addr_t wgt_addr_i,     // offset into weight table
    output snn_pkg::byte_t wgt_data_o,
    output snn_pkg::byte_t beta_o,
    output snn_pkg::byte_t vth_o
);

    localparam snn_pkg::addr_t IMG_END = snn_pkg::addr_t'(NUM_PIXELS);
    localparam snn_pkg::addr_t WGT_END = snn_pkg::addr_t'(NUM_PIXELS * (1 + NUM_NEURONS));

    snn_pkg::byte_t img_mem [NUM_PIXELS];
    snn_pkg::byte_t wgt_mem [NUM_WGT];
    snn_pkg::addr_t wgt_off;
    logic           wr_en;

    assign wr_en   = load_we_i && !busy_i;     // loader locked out during a run
    assign wgt_off = load_addr_i - IMG_END;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (load_addr_i == snn_pkg::BETA_ADDR) begin
                beta_o <= load_data_i;
            end else if (load_addr_i == snn_pkg::VTH_ADDR) begin
                vth_o <= load_data_i;
            end else if (load_addr_i < IMG_END) begin
                img_mem[load_addr_i[PIX_W-1:0]] <= load_data_i;
            end else if (load_addr_i < WGT_END) begin
                wgt_mem[wgt_off[WGT_W-1:0]] <= load_data_i;
            end
        end
    end

    // one cycle read latency on both ports
    always_ff @(posedge clk) begin
        if (img_rd_i) begin
            img_data_o <= img_mem[img_addr_i[PIX_W-1:0]];
        end
        if (wgt_rd_i) begin
            wgt_data_o <= wgt_mem[wgt_addr_i[WGT_W-1:0]];
        end
    end

    initial begin
        assert (NUM_PIXELS * (1 + NUM_NEURONS) <= 254)
            else $error("image and weights overlap the beta/vth registers");
    end

    // reads only come from a running controller, so they never meet a load
    a_rd_only_busy: assert property (@(posedge clk) (img_rd_i || wgt_rd_i) |-> busy_i)
        else $error("memory read outside a run");

endmodule

// ==== source/spike_encoder.sv ====
`timescale 1ns/10ps

module spike_encoder #(
    parameter int NUM_PIXELS = 16,
    localparam int PIX_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             seed_i,
    input  logic             pix_valid_i,
    input  logic [PIX_W-1:0] pix_idx_i,
    input  snn_pkg::byte_t   pix_data_i,
    output logic             push_o,
    output logic [PIX_W-1:0] push_idx_o
);

    snn_pkg::byte_t lfsr;
    logic           fb;

    assign fb = ^(lfsr & snn_pkg::LFSR_TAPS);

    always_ff @(posedge clk) begin
        if (rst || seed_i) begin
            lfsr <= snn_pkg::LFSR_SEED;
        end else if (pix_valid_i) begin
            lfsr <= {lfsr[6:0], fb};            // one step per pixel
        end
    end

    // strict compare, a dark pixel never fires
    assign push_o     = pix_valid_i && (lfsr < pix_data_i);
    assign push_idx_o = pix_idx_i;

endmodule

// ==== source/spike_queue.sv ====
`timescale 1ns/10ps

module spike_queue #(
    parameter int NUM_PIXELS = 16,
    localparam int PIX_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    localparam int CNT_W = $clog2(NUM_PIXELS + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear_i,
    input  logic             push_i,
    input  logic [PIX_W-1:0] push_idx_i,
    input  logic             pop_i,
    output logic [PIX_W-1:0] head_idx_o,
    output logic             empty_o
);

    logic [PIX_W-1:0] mem [NUM_PIXELS];
    logic [PIX_W-1:0] wr_ptr;
    logic [PIX_W-1:0] rd_ptr;
    logic [CNT_W-1:0] level;
    logic             full;

    function automatic logic [PIX_W-1:0] bump(input logic [PIX_W-1:0] p);
        return (p == PIX_W'(NUM_PIXELS - 1)) ? '0 : p + 1'b1;   // wrap at depth
    endfunction

    assign full       = (level == CNT_W'(NUM_PIXELS));
    assign empty_o    = (level == '0);
    assign head_idx_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push_i) wr_ptr <= bump(wr_ptr);
            if (pop_i) rd_ptr <= bump(rd_ptr);
            if (push_i && !pop_i) level <= level + 1'b1;
            else if (pop_i && !push_i) level <= level - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr] <= push_idx_i;
    end

    // depth covers one entry per pixel, the encoder can never outrun it
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push_i |-> !full)
        else $error("spike queue push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o)
        else $error("spike queue pop while empty");

endmodule

// ==== source/lif_neuron_array.sv ====
`timescale 1ns/10ps

module lif_neuron_array #(
    parameter int NUM_NEURONS = 4,
    localparam int NEU_W = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear_i,
    input  logic             integ_i,
    input  logic [NEU_W-1:0] integ_idx_i,
    input  snn_pkg::byte_t   weight_i,
    input  logic             leak_i,
    input  logic [NEU_W-1:0] leak_idx_i,
    input  snn_pkg::byte_t   beta_i,
    input  snn_pkg::byte_t   vth_i,
    input  logic [NEU_W-1:0] count_sel_i,
    output snn_pkg::count_t  count_o
);

    snn_pkg::byte_t  vmem [NUM_NEURONS];
    snn_pkg::count_t spk_cnt [NUM_NEURONS];

    logic [8:0]     sum;
    logic [15:0]    prod;
    snn_pkg::byte_t leaked;
    logic           fire;

    // integrate path
    assign sum = {1'b0, vmem[integ_idx_i]} + {1'b0, weight_i};

    // leak path, beta is a fraction of 256
    assign prod   = {8'd0, vmem[leak_idx_i]} * {8'd0, beta_i};
    assign leaked = prod[15:8];
    assign fire   = (leaked >= vth_i);

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            for (int i = 0; i < NUM_NEURONS; i++) begin
                vmem[i]    <= '0;
                spk_cnt[i] <= '0;
            end
        end else begin
            if (integ_i) begin
                vmem[integ_idx_i] <= sum[8] ? 8'hff : sum[7:0];   // clamp
            end
            if (leak_i) begin
                if (fire) begin
                    vmem[leak_idx_i] <= '0;         // reset after spike
                    if (spk_cnt[leak_idx_i] != 8'hff) begin
                        spk_cnt[leak_idx_i] <= spk_cnt[leak_idx_i] + 1'b1;
                    end
                end else begin
                    vmem[leak_idx_i] <= leaked;
                end
            end
        end
    end

    assign count_o = spk_cnt[count_sel_i];

endmodule

// ==== source/snn_controller.sv ====
`timescale 1ns/10ps

module snn_controller #(
    parameter int NUM_PIXELS  = 16,
    parameter int NUM_NEURONS = 4,
    parameter int NUM_STEPS   = 8,
    localparam int PIX_W  = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    localparam int PCW    = $clog2(NUM_PIXELS + 1),
    localparam int NEU_W  = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1,
    localparam int STEP_W = (NUM_STEPS > 1) ? $clog2(NUM_STEPS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    output logic             busy_o,
    output logic             done_o,
    output logic             img_rd_o,
    output snn_pkg::addr_t   img_addr_o,
    output logic             pix_valid_o,
    output logic [PIX_W-1:0] pix_idx_o,
    output logic             seed_o,
    output logic             q_clear_o,
    output logic             pop_o,
    input  logic [PIX_W-1:0] head_idx_i,
    input  logic             empty_i,
    output logic             wgt_rd_o,
    output snn_pkg::addr_t   wgt_addr_o,
    output logic             integ_o,
    output logic [NEU_W-1:0] integ_idx_o,
    output logic             leak_o,
    output logic [NEU_W-1:0] leak_idx_o,
    output logic             clear_o
);

    snn_pkg::state_t   state;
    logic [PCW-1:0]    pix_cnt;
    logic [NEU_W-1:0]  neu_cnt;
    logic [STEP_W-1:0] step_cnt;
    logic [PIX_W-1:0]  spike_pix;       // pixel row being integrated
    logic              gen_done;
    logic              last_neu;
    logic              last_step;

    assign gen_done  = (pix_cnt == PCW'(NUM_PIXELS));   // drain cycle, no read
    assign last_neu  = (neu_cnt == NEU_W'(NUM_NEURONS - 1));
    assign last_step = (step_cnt == STEP_W'(NUM_STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= snn_pkg::IDLE;
            pix_cnt  <= '0;
            neu_cnt  <= '0;
            step_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                snn_pkg::IDLE: begin
                    if (start_i) begin
                        step_cnt <= '0;
                        state    <= snn_pkg::CLEAR;
                    end
                end
                snn_pkg::CLEAR: begin
                    pix_cnt <= '0;
                    state   <= snn_pkg::GEN;
                end
                snn_pkg::GEN: begin
                    if (gen_done) state <= snn_pkg::POP;
                    else pix_cnt <= pix_cnt + 1'b1;
                end
                snn_pkg::POP: begin
                    neu_cnt <= '0;
                    state   <= empty_i ? snn_pkg::LEAK : snn_pkg::INTEG;
                end
                snn_pkg::INTEG: begin
                    neu_cnt <= neu_cnt + 1'b1;
                    if (last_neu) state <= snn_pkg::POP;
                end
                snn_pkg::LEAK: begin
                    neu_cnt <= neu_cnt + 1'b1;
                    if (last_neu) state <= snn_pkg::NEXT;
                end
                snn_pkg::NEXT: begin
                    if (last_step) begin
                        done_o <= 1'b1;
                        state  <= snn_pkg::IDLE;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                        pix_cnt  <= '0;
                        state    <= snn_pkg::GEN;
                    end
                end
                default: state <= snn_pkg::IDLE;
            endcase
        end
    end

    // read strobes delayed to line up with memory data
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid_o <= 1'b0;
            integ_o     <= 1'b0;
        end else begin
            pix_valid_o <= img_rd_o;
            integ_o     <= wgt_rd_o;
        end
    end

    always_ff @(posedge clk) begin
        pix_idx_o   <= PIX_W'(pix_cnt);
        integ_idx_o <= neu_cnt;
        if (state == snn_pkg::POP) spike_pix <= head_idx_i;
    end

    assign busy_o     = (state != snn_pkg::IDLE);
    assign seed_o     = (state == snn_pkg::CLEAR);
    assign q_clear_o  = (state == snn_pkg::CLEAR);
    assign clear_o    = (state == snn_pkg::CLEAR);
    assign img_rd_o   = (state == snn_pkg::GEN) && !gen_done;
    assign img_addr_o = snn_pkg::addr_t'(pix_cnt);
    assign pop_o      = (state == snn_pkg::POP) && !empty_i;
    assign wgt_rd_o   = (state == snn_pkg::INTEG);
    assign wgt_addr_o = snn_pkg::addr_t'(spike_pix) * snn_pkg::addr_t'(NUM_NEURONS)
                      + snn_pkg::addr_t'(neu_cnt);          // row of the popped pixel
    assign leak_o     = (state == snn_pkg::LEAK);
    assign leak_idx_o = neu_cnt;

    a_done_single: assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o)
        else $error("done_o held longer than one cycle");

endmodule

// ==== source/snn_core.sv ====
`timescale 1ns/10ps

module snn_core #(
    parameter int NUM_PIXELS  = 16,
    parameter int NUM_NEURONS = 4,
    parameter int NUM_STEPS   = 8,
    localparam int PIX_W = (NUM_PIXELS > 1) ? $clog2(NUM_PIXELS) : 1,
    localparam int NEU_W = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_we_i,
    input  snn_pkg::addr_t        load_addr_i,
    input  snn_pkg::byte_t        load_data_i,
    input  logic                  start_i,
    output logic                  busy_o,
    output logic                  done_o,
    input  logic [NEU_W-1:0]      count_sel_i,
    output snn_pkg::count_t       count_o
);

    logic img_rd, wgt_rd, pix_valid, seed, q_clear, pop, push, empty;
    logic integ, leak, clear;
    snn_pkg::addr_t img_addr, wgt_addr;
    snn_pkg::byte_t img_data, wgt_data, beta, vth;
    logic [PIX_W-1:0] pix_idx, push_idx, head_idx;
    logic [NEU_W-1:0] integ_idx, leak_idx;

    snn_store #(.NUM_PIXELS(NUM_PIXELS), .NUM_NEURONS(NUM_NEURONS)) snn_store_i (
        .clk(clk),
        .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .busy_i(busy_o),
        .img_rd_i(img_rd), .img_addr_i(img_addr), .img_data_o(img_data),
        .wgt_rd_i(wgt_rd), .wgt_addr_i(wgt_addr), .wgt_data_o(wgt_data),
        .beta_o(beta), .vth_o(vth)
    );

    snn_controller #(
        .NUM_PIXELS(NUM_PIXELS), .NUM_NEURONS(NUM_NEURONS), .NUM_STEPS(NUM_STEPS)
    ) snn_controller_i (
        .clk(clk), .rst(rst),
        .start_i(start_i), .busy_o(busy_o), .done_o(done_o),
        .img_rd_o(img_rd), .img_addr_o(img_addr),
        .pix_valid_o(pix_valid), .pix_idx_o(pix_idx),
        .seed_o(seed), .q_clear_o(q_clear),
        .pop_o(pop), .head_idx_i(head_idx), .empty_i(empty),
        .wgt_rd_o(wgt_rd), .wgt_addr_o(wgt_addr),
        .integ_o(integ), .integ_idx_o(integ_idx),
        .leak_o(leak), .leak_idx_o(leak_idx),
        .clear_o(clear)
    );

    spike_encoder #(.NUM_PIXELS(NUM_PIXELS)) spike_encoder_i (
        .clk(clk), .rst(rst), .seed_i(seed),
        .pix_valid_i(pix_valid), .pix_idx_i(pix_idx), .pix_data_i(img_data),
        .push_o(push), .push_idx_o(push_idx)
    );

    spike_queue #(.NUM_PIXELS(NUM_PIXELS)) spike_queue_i (
        .clk(clk), .rst(rst), .clear_i(q_clear),
        .push_i(push), .push_idx_i(push_idx),
        .pop_i(pop), .head_idx_o(head_idx), .empty_o(empty)
    );

    lif_neuron_array #(.NUM_NEURONS(NUM_NEURONS)) lif_neuron_array_i (
        .clk(clk), .rst(rst), .clear_i(clear),
        .integ_i(integ), .integ_idx_i(integ_idx), .weight_i(wgt_data),
        .leak_i(leak), .leak_idx_i(leak_idx),
        .beta_i(beta), .vth_i(vth),
        .count_sel_i(count_sel_i), .count_o(count_o)
    );

endmodule

// ==== sim/snn_core_tb.sv ====
`timescale 1ns/10ps

module snn_core_tb;

    localparam int NUM_PIXELS  = 16;
    localparam int NUM_NEURONS = 4;
    localparam int NUM_STEPS   = 8;
    localparam int NEU_W       = $clog2(NUM_NEURONS);
    localparam int WGT_END     = NUM_PIXELS * (1 + NUM_NEURONS);    // image plus weights
    localparam int RUN_BYTES   = WGT_END + 2 + NUM_NEURONS;         // + beta, vth, counts
    localparam int NUM_RUNS    = 3;
    localparam int BUSY_LIMIT  = 10;
    localparam int DONE_LIMIT  = 4000;
    localparam int IDLE_CHECK  = 30;

    logic            clk;
    logic            rst;
    logic            load_we_i;
    snn_pkg::addr_t  load_addr_i;
    snn_pkg::byte_t  load_data_i;
    logic            start_i;
    logic            busy_o;
    logic            done_o;
    logic [NEU_W-1:0] count_sel_i;
    snn_pkg::count_t count_o;

    logic [7:0] trace_mem [NUM_RUNS * RUN_BYTES];
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;

    snn_core #(
        .NUM_PIXELS(NUM_PIXELS), .NUM_NEURONS(NUM_NEURONS), .NUM_STEPS(NUM_STEPS)
    ) snn_core_i (
        .clk(clk), .rst(rst),
        .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .start_i(start_i), .busy_o(busy_o), .done_o(done_o),
        .count_sel_i(count_sel_i), .count_o(count_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic write_loader(input snn_pkg::addr_t addr, input snn_pkg::byte_t data);
        @(posedge clk);
        load_we_i   <= 1'b1;
        load_addr_i <= addr;
        load_data_i <= data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        load_we_i <= 1'b0;
    endtask

    // trace offsets below WGT_END are loader addresses as they stand
    task automatic load_run(input int r);
        int base;
        base = r * RUN_BYTES;
        for (int a = 0; a < WGT_END; a++) begin
            write_loader(snn_pkg::addr_t'(a), trace_mem[base + a]);
        end
        write_loader(snn_pkg::BETA_ADDR, trace_mem[base + WGT_END]);
        write_loader(snn_pkg::VTH_ADDR, trace_mem[base + WGT_END + 1]);
        end_writes();
    endtask

    // bright image and zero threshold would move every count if they got through
    task automatic scribble();
        for (int a = 0; a < NUM_PIXELS; a++) begin
            write_loader(snn_pkg::addr_t'(a), 8'hff);
        end
        write_loader(snn_pkg::BETA_ADDR, 8'hff);
        write_loader(snn_pkg::VTH_ADDR, 8'h00);
        end_writes();
        @(negedge clk);
        assert (busy_o) else begin
            errors++;
            $display("run ended before the loader writes were over");
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        @(negedge clk);
        while (!busy_o && n < BUSY_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (busy_o) else begin
            errors++;
            $display("busy_o did not rise within %0d cycles of start", BUSY_LIMIT);
        end
    endtask

    // a start taken while busy would show up here as a second run
    task automatic check_idle();
        for (int n = 0; n < IDLE_CHECK; n++) begin
            @(negedge clk);
            assert (!busy_o && !done_o) else begin
                errors++;
                $display("activity after done: busy_o=%h done_o=%h", busy_o, done_o);
            end
        end
    endtask

    task automatic wait_done();
        int n;
        logic busy_prev;    // busy_o one cycle before done
        n = 0;
        busy_prev = busy_o;
        while (!done_o && n < DONE_LIMIT) begin
            busy_prev = busy_o;
            @(negedge clk);
            n++;
        end
        assert (done_o) else begin
            errors++;
            $display("done_o did not arrive within %0d cycles", DONE_LIMIT);
        end
        if (done_o) begin
            assert (busy_prev) else begin
                errors++;
                $display("Mismatch busy_o before done: got %h, expected %h", busy_prev, 1'b1);
            end
            assert (!busy_o) else begin
                errors++;
                $display("Mismatch busy_o at done: got %h, expected %h", busy_o, 1'b0);
            end
            @(negedge clk);
            assert (!done_o) else begin
                errors++;
                $display("done_o stayed high for more than one cycle");
            end
            check_idle();
        end
    endtask

    task automatic check_count(input int j, input snn_pkg::count_t expected);
        @(posedge clk);
        count_sel_i <= NEU_W'(j);
        @(negedge clk);
        assert (count_o == expected) else begin
            errors++;
            $display("Mismatch count_o neuron %0d: got %h, expected %h", j, count_o, expected);
        end
    endtask

    task automatic report(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_test(input string name, input int r, input bit reload,
                            input bit extra_start, input bit busy_writes);
        int errors_before;
        errors_before = errors;
        if (reload) begin
            load_run(r);
        end
        pulse_start();
        wait_busy();
        if (extra_start) begin
            pulse_start();      // controller is in CLEAR or GEN by now
        end
        if (busy_writes) begin
            scribble();
        end
        wait_done();
        for (int j = 0; j < NUM_NEURONS; j++) begin
            check_count(j, trace_mem[r * RUN_BYTES + WGT_END + 2 + j]);
        end
        report(name, errors_before);
    endtask

    initial begin
        int errors_before;
        rst         <= 1'b1;
        load_we_i   <= 1'b0;
        load_addr_i <= '0;
        load_data_i <= '0;
        start_i     <= 1'b0;
        count_sel_i <= '0;
        $readmemh("sim/snn_trace.txt", trace_mem);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        errors_before = errors;
        @(negedge clk);
        assert (!$isunknown(trace_mem[NUM_RUNS * RUN_BYTES - 1])) else begin
            errors++;
            $display("trace file is missing or shorter than %0d bytes", NUM_RUNS * RUN_BYTES);
        end
        assert (!busy_o && !done_o) else begin
            errors++;
            $display("Mismatch busy_o/done_o after reset: got %h/%h, expected 0/0",
                     busy_o, done_o);
        end
        for (int j = 0; j < NUM_NEURONS; j++) begin
            check_count(j, 8'h00);
        end
        report("reset state", errors_before);

        run_test("run 0", 0, 1'b1, 1'b0, 1'b0);
        run_test("run 0 repeated", 0, 1'b0, 1'b0, 1'b0);    // start clears and reseeds
        run_test("run 1 zero image", 1, 1'b1, 1'b0, 1'b0);
        run_test("run 2 start while busy", 2, 1'b1, 1'b1, 1'b0);
        run_test("run 2 loads while busy", 2, 1'b0, 1'b0, 1'b1);
        run_test("run 2 after blocked loads", 2, 1'b0, 1'b0, 1'b0);

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/snn_trace.txt ====
// per run: one line of pixels 0..15, four weight lines (pixels 4k..4k+3, neurons 0..3 each),
// then beta, vth and the expected spike counts of neurons 0..3
// run 0: pixels 2 7 9 13 at ff, beta 0.75, vth 0x30
00 00 ff 00 00 00 00 ff 00 ff 00 00 00 ff 00 00
40 20 10 08 21 43 65 07 0a 08 80 05 19 2a 3b 4c
55 66 77 08 01 02 03 04 7f 3e 2d 1c 0a 08 80 05
12 34 56 78 0a 08 80 05 60 50 40 30 9a bc de f0
0f 1e 2d 3c 0a 08 80 05 44 33 22 11 ff ee dd cc
c0 30 04 02 08 01
// run 1: dark image, same weights and leak
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
40 20 10 08 21 43 65 07 0a 08 80 05 19 2a 3b 4c
55 66 77 08 01 02 03 04 7f 3e 2d 1c 0a 08 80 05
12 34 56 78 0a 08 80 05 60 50 40 30 9a bc de f0
0f 1e 2d 3c 0a 08 80 05 44 33 22 11 ff ee dd cc
c0 30 00 00 00 00
// run 2: pixels 0 and 15 at ff, beta 0.5, vth 0x40
ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff
80 30 28 00 11 11 11 11 22 22 22 22 33 33 33 33
44 44 44 44 55 55 55 55 66 66 66 66 77 77 77 77
88 88 88 88 99 99 99 99 aa aa aa aa bb bb bb bb
cc cc cc cc dd dd dd dd ee ee ee ee 80 30 28 00
80 40 08 04 02 00

// ==== snn_core.f ====
source/snn_pkg.sv
source/snn_store.sv
source/spike_encoder.sv
source/spike_queue.sv
source/lif_neuron_array.sv
source/snn_controller.sv
source/snn_core.sv
sim/snn_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        -f snn_core.f --top-module snn_core_tb -o snn_core_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/snn_core_sim); then
    echo "$output"
    echo "simulation exited with an error"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
